// ==== files.f ====
src/esg_cfg_pkg.sv
src/esg_types_pkg.sv
src/esg_input_sync.sv
src/esg_phase_seq.sv
src/esg_sample_avg.sv
src/esg_err_calc.sv
src/esg_top.sv
sim/esg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module esg_tb -f files.f -o esg_sim
./obj_dir/esg_sim > sim.log 2>&1
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== sim/esg_tb.sv ====
`default_nettype none

module esg_tb
	import esg_cfg_pkg::*;
();

	localparam int ADC_BIT   = 14;
	localparam int AVG_LOG2  = 3;
	localparam int FREQ_CNT  = 20;
	localparam int SETTLE    = FREQ_CNT / 2;
	localparam int BOUND     = SETTLE + (1 << AVG_LOG2) + 8; // Trigger to o_sync limit
	localparam int SYNC_WAIT = 4; // Status and polarity through the two flops
	localparam int REF_WAIT  = BOUND + 4;
	localparam int NUM_ROWS  = 12;
	localparam int TIMEOUT   = NUM_ROWS * BOUND + 200;

	typedef enum logic [1:0] {
		ROW_REF,  // Realign and take a reference, no trigger
		ROW_MEAS, // Trigger and wait for o_sync
		ROW_GATE  // Trigger while the phase level does not match
	} row_kind_e;

	typedef struct packed {
		row_kind_e               kind;
		logic                    polarity;
		logic                    status;
		logic signed [ERR_W-1:0] adc;
		logic signed [ERR_W-1:0] offset;
		logic signed [ERR_W-1:0] exp_err;
	} row_t;

	logic                      i_clk;
	logic                      i_rst_n;
	logic                      i_status;
	logic                      i_polarity;
	logic                      i_trig;
	logic        [CNT_W-1:0]   i_freq_cnt;
	logic signed [ERR_W-1:0]   i_err_offset;
	logic signed [ADC_BIT-1:0] i_adc_data;
	logic signed [ERR_W-1:0]   o_err;
	logic                      o_sync;

	row_t  rows [NUM_ROWS];
	string row_names [NUM_ROWS];
	int    value_errs;
	int    event_errs;
	int    cycle_cnt;

	esg_top #(.ADC_BIT(ADC_BIT), .AVG_LOG2(AVG_LOG2)) esg_top_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_status     (i_status),
		.i_polarity   (i_polarity),
		.i_trig       (i_trig),
		.i_freq_cnt   (i_freq_cnt),
		.i_err_offset (i_err_offset),
		.i_adc_data   (i_adc_data),
		.o_err        (o_err),
		.o_sync       (o_sync)
	);

	task set_row(input int idx, input string name, input row_kind_e kind, input logic pol,
		input logic st, input int adc, input int offset, input int exp_err);
		row_names[idx] = name;
		rows[idx] = '{kind: kind, polarity: pol, status: st, adc: adc, offset: offset,
			exp_err: exp_err};
	endtask

	// Error rule: meas - ref + offset, difference negated on every other result
	task build_table;
		set_row(0, "reset_ref", ROW_REF, 1'b1, 1'b0, 100, 5, 0);
		set_row(1, "first_err", ROW_MEAS, 1'b1, 1'b0, 340, 5, 245);      // 340 - 100 + 5
		set_row(2, "alternate", ROW_MEAS, 1'b1, 1'b0, 300, 5, 45);       // -(300 - 340) + 5
		set_row(3, "neg_sample", ROW_MEAS, 1'b1, 1'b0, -2000, -7, -2307); // -2000 - 300 - 7
		set_row(4, "neg_alt", ROW_MEAS, 1'b1, 1'b0, -8000, -7, 5993);
		set_row(5, "neg_back", ROW_MEAS, 1'b1, 1'b0, 1500, -7, 9493);    // 1500 + 8000 - 7
		set_row(6, "pol_ref", ROW_REF, 1'b0, 1'b1, 1000, 3, 9493);       // o_err holds
		set_row(7, "pol_first", ROW_MEAS, 1'b0, 1'b1, 1200, 3, 203);     // Positive again
		set_row(8, "gate_a", ROW_GATE, 1'b1, 1'b1, 600, 3, 203);
		set_row(9, "gate_b", ROW_GATE, 1'b1, 1'b1, 700, 3, 203);
		set_row(10, "release_ref", ROW_REF, 1'b1, 1'b0, -500, -1, 203);
		set_row(11, "release_err", ROW_MEAS, 1'b1, 1'b0, 250, -1, 749);  // 250 + 500 - 1
	endtask

	task apply_row(input int idx);
		@(posedge i_clk);
		i_polarity   <= rows[idx].polarity;
		i_status     <= rows[idx].status;
		i_adc_data   <= rows[idx].adc[ADC_BIT-1:0];
		i_err_offset <= rows[idx].offset;
	endtask

	task pulse_trig;
		@(posedge i_clk);
		i_trig <= 1'b1;
		@(posedge i_clk);
		i_trig <= 1'b0;
	endtask

	// Sampled on the falling edge, returns on the first o_sync
	task wait_for_sync(input int max_cycles, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < max_cycles) begin
			@(negedge i_clk);
			seen = o_sync;
			n++;
		end
	endtask

	task count_syncs(input int cycles, output int pulses);
		pulses = 0;
		repeat (cycles) begin
			@(negedge i_clk);
			if (o_sync)
				pulses++;
		end
	endtask

	task check_value(input string name, input int exp_val, input int act_val);
		assert (act_val == exp_val) else begin
			value_errs++;
			$display("FAILED %s: expected %0d, actual %0d", name, exp_val, act_val);
		end
	endtask

	task run_row(input int idx);
		bit seen;
		int pulses;
		apply_row(idx);
		repeat (SYNC_WAIT) @(posedge i_clk);
		case (rows[idx].kind)
			ROW_MEAS: begin
				pulse_trig();
				wait_for_sync(BOUND, seen);
				assert (seen) else begin
					event_errs++;
					$display("Row %s: no o_sync within %0d cycles after the trigger",
						row_names[idx], BOUND);
				end
			end
			ROW_GATE: begin
				pulse_trig();
				count_syncs(BOUND, pulses);
				assert (pulses == 0) else begin
					event_errs++;
					$display("Row %s: o_sync pulsed %0d times while the phase level did not match",
						row_names[idx], pulses);
				end
			end
			default: begin
				count_syncs(REF_WAIT, pulses);
				assert (pulses == 0) else begin
					event_errs++;
					$display("Row %s: o_sync pulsed during the reference acquisition",
						row_names[idx]);
				end
			end
		endcase
		check_value(row_names[idx], rows[idx].exp_err, o_err);
	endtask

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT) begin
			@(posedge i_clk);
			cycle_cnt++;
		end
		$display("Run stopped after %0d cycles before the stimulus table was done", TIMEOUT);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		i_rst_n      = 1'b0;
		i_status     = 1'b0;
		i_polarity   = 1'b1;
		i_trig       = 1'b0;
		i_freq_cnt   = CNT_W'(FREQ_CNT);
		i_err_offset = '0;
		i_adc_data   = '0;
		value_errs   = 0;
		event_errs   = 0;
		build_table();
		repeat (3) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		check_value("reset_sync", 0, int'(o_sync));
		check_value("reset_err", 0, o_err);
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(i);
		end
		$display("Summary: %0d rows, %0d value errors, %0d other errors",
			NUM_ROWS, value_errs, event_errs);
		if (value_errs + event_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/esg_cfg_pkg.sv ====
`default_nettype none

package esg_cfg_pkg;

	// Internal signed word width, also the width of o_err
	localparam int ERR_W = 32;

	// Frequency and settle counter width
	localparam int CNT_W = 32;

	localparam logic [CNT_W-1:0] SETTLE_RST = 25; // Used until i_freq_cnt is registered

endpackage

`default_nettype wire

// ==== src/esg_err_calc.sv ====
`default_nettype none

module esg_err_calc
	import esg_cfg_pkg::*, esg_types_pkg::*;
(
	input  wire                     i_clk,
	input  wire                     i_rst_n,
	input  wire esg_acq_rsp_t       i_acq_rsp,
	input  wire                     i_err_stb,
	input  wire signed [ERR_W-1:0]  i_offset,
	output logic signed [ERR_W-1:0] o_err,
	output logic                    o_sync
);

	logic signed [ERR_W-1:0] ref_q;
	logic signed [ERR_W-1:0] meas_q;
	logic signed [ERR_W-1:0] diff;
	logic flip_q;       // Negate the next result
	logic ref_ok_q;
	logic ref_load;
	logic meas_load;

	assign ref_load  = i_acq_rsp.done && (i_acq_rsp.op == OP_REF);
	assign meas_load = i_acq_rsp.done && (i_acq_rsp.op == OP_MEAS);
	assign diff      = meas_q - ref_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_err    <= '0;
			o_sync   <= 1'b0;
			flip_q   <= 1'b0;
			ref_ok_q <= 1'b0;
		end else begin
			o_sync <= i_err_stb;
			if (ref_load) begin
				flip_q   <= 1'b0; // Realigned, restart positive
				ref_ok_q <= 1'b1;
			end else if (i_err_stb) begin
				o_err  <= (flip_q ? -diff : diff) + i_offset;
				flip_q <= ~flip_q;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (ref_load)
			ref_q <= i_acq_rsp.mean;
		else if (i_err_stb)
			ref_q <= meas_q; // Measurement becomes the new reference
		if (meas_load)
			meas_q <= i_acq_rsp.mean;
	end

	a_ref_before_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_err_stb |-> ref_ok_q);

endmodule

`default_nettype wire

// ==== src/esg_input_sync.sv ====
`default_nettype none

module esg_input_sync
	import esg_cfg_pkg::*, esg_types_pkg::*;
#(
	parameter int ADC_BIT = 14
) (
	input  wire                       i_clk,
	input  wire                       i_rst_n,
	input  wire                       i_status,
	input  wire                       i_polarity,
	input  wire                       i_trig,
	input  wire        [CNT_W-1:0]    i_freq_cnt,
	input  wire signed [ERR_W-1:0]    i_err_offset,
	input  wire signed [ADC_BIT-1:0]  i_adc_data,
	output esg_sample_t               o_sample,
	output logic       [CNT_W-1:0]    o_settle_cnt,
	output logic signed [ERR_W-1:0]   o_offset
);

	logic status_meta;
	logic status_sync;
	logic pol_meta;
	logic pol_sync;
	logic pol_prev;
	logic trig_q;
	logic signed [ERR_W-1:0] adc_ext;
	logic signed [ERR_W-1:0] adc_q;

	assign adc_ext = {{(ERR_W-ADC_BIT){i_adc_data[ADC_BIT-1]}}, i_adc_data}; // Sign extend

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			status_meta  <= 1'b0;
			status_sync  <= 1'b0;
			pol_meta     <= 1'b1;
			pol_sync     <= 1'b1;
			pol_prev     <= 1'b1;
			trig_q       <= 1'b0;
			o_settle_cnt <= SETTLE_RST;
		end else begin
			status_meta  <= i_status;
			status_sync  <= status_meta;
			pol_meta     <= i_polarity;
			pol_sync     <= pol_meta;
			pol_prev     <= pol_sync;
			trig_q       <= i_trig;
			o_settle_cnt <= i_freq_cnt >> 1; // Half of the modulation count
		end
	end

	always_ff @(posedge i_clk) begin
		adc_q    <= adc_ext;
		o_offset <= i_err_offset;
	end

	assign o_sample = '{
		adc:        adc_q,
		status:     status_sync,
		polarity:   pol_sync,
		trig:       trig_q,
		pol_change: pol_sync ^ pol_prev // High for one cycle per edge
	};

endmodule

`default_nettype wire

// ==== src/esg_phase_seq.sv ====
`default_nettype none

module esg_phase_seq
	import esg_cfg_pkg::*, esg_types_pkg::*;
(
	input  wire                 i_clk,
	input  wire                 i_rst_n,
	input  wire esg_sample_t    i_sample,
	input  wire [CNT_W-1:0]     i_settle_cnt,
	input  wire esg_acq_rsp_t   i_acq_rsp,
	output esg_acq_cmd_t        o_acq_cmd,
	output logic                o_err_stb
);

	esg_state_e state_q;
	esg_state_e state_d;
	logic [CNT_W-1:0] settle_q;
	logic settle_done;
	logic init_q;        // Next acquisition becomes the reference
	logic start_q;
	esg_acq_op_e op_q;

	assign settle_done = (settle_q == '0);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_RST: state_d = i_sample.polarity ? ST_WAIT_LOW : ST_WAIT_HIGH;
			ST_WAIT_LOW: begin
				if (i_sample.pol_change)
					state_d = ST_RST; // Synchronizer still settling after reset
				else if (!i_sample.status)
					state_d = ST_SETTLE;
			end
			ST_WAIT_HIGH: begin
				if (i_sample.pol_change)
					state_d = ST_RST;
				else if (i_sample.status)
					state_d = ST_SETTLE;
			end
			ST_SETTLE: begin
				if (i_sample.pol_change)
					state_d = ST_RST;
				else if (settle_done)
					state_d = init_q ? ST_ACQ_REF : ST_ACQ_MEAS;
			end
			ST_ACQ_REF: begin
				if (i_acq_rsp.done && i_acq_rsp.op == OP_REF)
					state_d = ST_WAIT_TRIG;
			end
			ST_ACQ_MEAS: begin
				if (i_acq_rsp.done && i_acq_rsp.op == OP_MEAS)
					state_d = ST_ERR;
			end
			ST_ERR: state_d = ST_WAIT_TRIG;
			ST_WAIT_TRIG: begin
				if (i_sample.pol_change)
					state_d = ST_RST;
				else if (i_sample.trig)
					state_d = ST_SETTLE;
			end
			default: state_d = ST_RST;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q   <= ST_RST;
			settle_q  <= SETTLE_RST;
			init_q    <= 1'b1;
			start_q   <= 1'b0;
			op_q      <= OP_REF;
			o_err_stb <= 1'b0;
		end else begin
			state_q <= state_d;

			if (state_q != ST_SETTLE)
				settle_q <= i_settle_cnt; // Reloaded on every entry
			else if (!settle_done)
				settle_q <= settle_q - CNT_W'(1);

			if (state_q == ST_RST)
				init_q <= 1'b1;
			else if (state_q == ST_ACQ_REF && state_d == ST_WAIT_TRIG)
				init_q <= 1'b0;

			start_q   <= (state_q == ST_SETTLE) && (state_d inside {ST_ACQ_REF, ST_ACQ_MEAS});
			op_q      <= init_q ? OP_REF : OP_MEAS;
			o_err_stb <= (state_q == ST_ACQ_MEAS) && (state_d == ST_ERR); // High during ST_ERR
		end
	end

	assign o_acq_cmd = '{start: start_q, op: op_q};

	a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!$isunknown(state_q) && state_q inside {ST_RST, ST_WAIT_LOW, ST_WAIT_HIGH,
			ST_SETTLE, ST_ACQ_REF, ST_ACQ_MEAS, ST_ERR, ST_WAIT_TRIG});

endmodule

`default_nettype wire

// ==== src/esg_sample_avg.sv ====
`default_nettype none

module esg_sample_avg
	import esg_cfg_pkg::*, esg_types_pkg::*;
#(
	parameter int AVG_LOG2 = 3
) (
	input  wire                     i_clk,
	input  wire                     i_rst_n,
	input  wire esg_acq_cmd_t       i_acq_cmd,
	input  wire signed [ERR_W-1:0]  i_adc,
	output esg_acq_rsp_t            o_acq_rsp
);

	localparam logic [AVG_LOG2:0] N_SMP = (AVG_LOG2+1)'(1) << AVG_LOG2;

	logic busy_q;
	logic [AVG_LOG2:0] cnt_q;   // Samples left after this one
	esg_acq_op_e op_q;
	logic done_q;
	esg_acq_op_e rsp_op_q;
	logic signed [ERR_W-1:0] acc_q;
	logic signed [ERR_W-1:0] acc_next;
	logic signed [ERR_W-1:0] mean_q;
	logic last;

	assign last     = busy_q && (cnt_q == '0);
	assign acc_next = acc_q + i_adc;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy_q   <= 1'b0;
			cnt_q    <= '0;
			op_q     <= OP_REF;
			done_q   <= 1'b0;
			rsp_op_q <= OP_REF;
		end else begin
			done_q <= 1'b0;
			if (i_acq_cmd.start) begin
				busy_q <= 1'b1;
				cnt_q  <= N_SMP - (AVG_LOG2+1)'(1);
				op_q   <= i_acq_cmd.op;
			end else if (last) begin
				busy_q   <= 1'b0;
				done_q   <= 1'b1;
				rsp_op_q <= op_q;
			end else if (busy_q) begin
				cnt_q <= cnt_q - (AVG_LOG2+1)'(1);
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_acq_cmd.start)
			acc_q <= '0;
		else if (busy_q)
			acc_q <= acc_next;
		if (last)
			mean_q <= acc_next >>> AVG_LOG2; // Keeps the sign
	end

	assign o_acq_rsp = '{done: done_q, op: rsp_op_q, mean: mean_q};

	a_no_start_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_acq_cmd.start |-> !busy_q);

endmodule

`default_nettype wire

// ==== src/esg_top.sv ====
`default_nettype none

module esg_top
	import esg_cfg_pkg::*, esg_types_pkg::*;
#(
	parameter int ADC_BIT  = 14,
	parameter int AVG_LOG2 = 3
) (
	input  wire                       i_clk,
	input  wire                       i_rst_n,
	input  wire                       i_status,
	input  wire                       i_polarity,
	input  wire                       i_trig,
	input  wire        [CNT_W-1:0]    i_freq_cnt,
	input  wire signed [ERR_W-1:0]    i_err_offset,
	input  wire signed [ADC_BIT-1:0]  i_adc_data,
	output logic signed [ERR_W-1:0]   o_err,
	output logic                      o_sync
);

	esg_sample_t sample;
	logic [CNT_W-1:0] settle_cnt;
	logic signed [ERR_W-1:0] offset;
	esg_acq_cmd_t acq_cmd;
	esg_acq_rsp_t acq_rsp;
	logic err_stb;

	esg_input_sync #(.ADC_BIT(ADC_BIT)) esg_input_sync_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_status     (i_status),
		.i_polarity   (i_polarity),
		.i_trig       (i_trig),
		.i_freq_cnt   (i_freq_cnt),
		.i_err_offset (i_err_offset),
		.i_adc_data   (i_adc_data),
		.o_sample     (sample),
		.o_settle_cnt (settle_cnt),
		.o_offset     (offset)
	);

	esg_phase_seq esg_phase_seq_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_sample     (sample),
		.i_settle_cnt (settle_cnt),
		.i_acq_rsp    (acq_rsp),
		.o_acq_cmd    (acq_cmd),
		.o_err_stb    (err_stb)
	);

	esg_sample_avg #(.AVG_LOG2(AVG_LOG2)) esg_sample_avg_inst (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_acq_cmd (acq_cmd),
		.i_adc     (sample.adc),
		.o_acq_rsp (acq_rsp)
	);

	esg_err_calc esg_err_calc_inst (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_acq_rsp (acq_rsp),
		.i_err_stb (err_stb),
		.i_offset  (offset),
		.o_err     (o_err),
		.o_sync    (o_sync)
	);

endmodule

`default_nettype wire

// ==== src/esg_types_pkg.sv ====
`default_nettype none

package esg_types_pkg;
	import esg_cfg_pkg::*;

	// One conditioned input cycle
	typedef struct packed {
		logic signed [ERR_W-1:0] adc;        // Sign-extended sample
		logic                    status;     // Synchronized phase level
		logic                    polarity;   // Synchronized polarity
		logic                    trig;       // Registered trigger
		logic                    pol_change; // Single-cycle pulse
	} esg_sample_t;

	typedef enum logic [3:0] {
		ST_RST       = 4'd0,
		ST_WAIT_LOW  = 4'd1,
		ST_WAIT_HIGH = 4'd2,
		ST_SETTLE    = 4'd3,
		ST_ACQ_REF   = 4'd4,
		ST_ACQ_MEAS  = 4'd5,
		ST_ERR       = 4'd6,
		ST_WAIT_TRIG = 4'd7
	} esg_state_e;

	typedef enum logic {
		OP_REF  = 1'b0,
		OP_MEAS = 1'b1
	} esg_acq_op_e;

	typedef struct packed {
		logic        start;
		esg_acq_op_e op;
	} esg_acq_cmd_t;

	typedef struct packed {
		logic                    done;
		esg_acq_op_e             op;   // Echo of the command op
		logic signed [ERR_W-1:0] mean;
	} esg_acq_rsp_t;

endpackage

`default_nettype wire
